// File: build.f
mprog_pkg.sv
mprog_front.sv
mprog_param_regs.sv
mprog_cmd_seq.sv
mprog_port_arb.sv
mprog_top.sv
tb_clk_gen.sv
tb_mprog.sv

// File: mprog_cmd_seq.sv
module mprog_cmd_seq (
   input  logic                    clk_i,
   input  logic                    rst_ni,
   input  logic                    prog_start_i,
   input  mprog_pkg::prog_params_t params_i,
   output mprog_pkg::mem_req_t     seq_req_o,
   input  logic                    seq_gnt_i,
   output logic                    seq_busy_o
);

   // five words per transfer
   typedef enum logic [2:0] {W_CMD, W_TCDM, W_EXT, W_ESTR, W_TSTR} word_e;

   word_e                          word_q;
   logic                           busy_q;
   logic [mprog_pkg::CNT_W-1:0]    cnt_tr_q;
   logic [mprog_pkg::CNT_W-1:0]    cnt_batch_q;
   logic [mprog_pkg::ADDR_W-1:0]   tcdm_addr_q;
   logic [mprog_pkg::ADDR_W-1:0]   ext_addr_q;
   logic [mprog_pkg::ADDR_W-1:0]   ext_batch_q;
   logic [mprog_pkg::ADDR_W-1:0]   slot_ext;
   logic [mprog_pkg::SIZE_W-1:0]   size;
   logic [mprog_pkg::DATA_W-1:0]   wdata;
   logic                           last_tr;
   logic                           last_batch;
   logic                           step;

   assign slot_ext = {{(mprog_pkg::ADDR_W - mprog_pkg::HALF_W){1'b0}}, params_i.slot_size};

   assign last_tr    = (cnt_tr_q == params_i.num_tr - 1'b1);
   assign last_batch = (cnt_batch_q == params_i.num_batch - 1'b1);
   assign step       = busy_q && seq_gnt_i;

   // final batch switches to the short size
   assign size = last_batch ? params_i.last_size : params_i.max_size;

   always_comb begin
      unique case (word_q)
         W_CMD:   wdata = {params_i.cmd_flags, size};
         W_TCDM:  wdata = tcdm_addr_q;
         W_EXT:   wdata = ext_addr_q;
         W_ESTR:  wdata = params_i.ext_stride;
         W_TSTR:  wdata = params_i.tcdm_stride;
         default: wdata = '0;
      endcase
   end

   always_comb begin
      seq_req_o.req   = busy_q;
      seq_req_o.wen   = 1'b0;
      seq_req_o.be    = '1;
      seq_req_o.addr  = params_i.cmd_addr;
      seq_req_o.wdata = wdata;
   end

   assign seq_busy_o = busy_q;

   // control counters
   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         busy_q      <= 1'b0;
         word_q      <= W_CMD;
         cnt_tr_q    <= '0;
         cnt_batch_q <= '0;
      end else if (prog_start_i && !busy_q) begin
         // empty programs never start
         busy_q      <= (params_i.num_batch != '0) && (params_i.num_tr != '0);
         word_q      <= W_CMD;
         cnt_tr_q    <= '0;
         cnt_batch_q <= '0;
      end else if (step) begin
         if (word_q != W_TSTR) begin
            word_q <= word_e'(word_q + 3'd1);
         end else begin
            word_q <= W_CMD;
            if (!last_tr) begin
               cnt_tr_q <= cnt_tr_q + 1'b1;
            end else begin
               cnt_tr_q <= '0;
               if (last_batch) begin
                  busy_q <= 1'b0;
               end else begin
                  cnt_batch_q <= cnt_batch_q + 1'b1;
               end
            end
         end
      end
   end

   // address accumulators, local runs on, external restarts per batch
   always_ff @(posedge clk_i) begin
      if (prog_start_i && !busy_q) begin
         tcdm_addr_q <= params_i.tcdm_base;
         ext_addr_q  <= params_i.ext_base;
         ext_batch_q <= params_i.ext_base;
      end else if (step && word_q == W_TSTR) begin
         tcdm_addr_q <= tcdm_addr_q + slot_ext;
         if (!last_tr) begin
            ext_addr_q <= ext_addr_q + params_i.ext_stride;
         end else begin
            ext_addr_q  <= ext_batch_q + params_i.batch_ofs;
            ext_batch_q <= ext_batch_q + params_i.batch_ofs;
         end
      end
   end

endmodule

// File: mprog_front.sv
module mprog_front (
   input  logic                 clk_i,
   input  logic                 rst_ni,
   input  mprog_pkg::mem_req_t  core_req_i,
   output mprog_pkg::mem_rsp_t  core_rsp_o,
   output mprog_pkg::mem_req_t  pt_req_o,
   input  mprog_pkg::mem_rsp_t  pt_rsp_i,
   input  logic                 seq_busy_i,
   output logic                 cap_we_o,
   output logic [2:0]           cap_idx_o,
   output mprog_pkg::mem_req_t  cap_word_o,
   output logic                 prog_start_o
);

   typedef enum logic [2:0] {IDLE, PT_WAIT, CAP_GNT, CAP_VALID, CAP_WAIT, START} state_e;

   state_e                      state_q, state_d;
   logic [3:0]                  cnt_q;
   logic [mprog_pkg::OPC_W-1:0] opc;
   logic                        full_wr;
   logic                        trigger;
   logic                        fwd;

   assign opc     = core_req_i.wdata[mprog_pkg::OPC_LSB +: mprog_pkg::OPC_W];
   assign full_wr = core_req_i.req && !core_req_i.wen && (core_req_i.be == '1);
   assign trigger = full_wr && (opc == mprog_pkg::OPC_PROG_A || opc == mprog_pkg::OPC_PROG_B);

   // anything that is not a trigger goes straight to the dma port
   assign fwd = (state_q == IDLE) && core_req_i.req && !trigger;

   // a trigger waits here while the sequencer still runs
   assign cap_we_o = (state_q == IDLE && trigger && !seq_busy_i) ||
                     (state_q == CAP_WAIT && full_wr);
   assign cap_idx_o    = cnt_q[2:0];
   assign cap_word_o   = core_req_i;
   assign prog_start_o = (state_q == START);

   always_comb begin
      pt_req_o     = core_req_i;
      pt_req_o.req = fwd;
   end

   always_comb begin
      core_rsp_o.gnt     = fwd ? pt_rsp_i.gnt : (state_q == CAP_GNT);
      core_rsp_o.r_valid = (state_q == PT_WAIT) ? pt_rsp_i.r_valid : (state_q == CAP_VALID);
      core_rsp_o.r_rdata = pt_rsp_i.r_rdata;
   end

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         IDLE: begin
            if (cap_we_o) begin
               state_d = CAP_GNT;
            end else if (fwd && pt_rsp_i.gnt) begin
               state_d = PT_WAIT;
            end
         end
         PT_WAIT: begin
            if (pt_rsp_i.r_valid) begin
               state_d = IDLE;
            end
         end
         CAP_GNT:   state_d = CAP_VALID;
         CAP_VALID: state_d = (cnt_q == mprog_pkg::NUM_PARAM_WORDS) ? START : CAP_WAIT;
         CAP_WAIT: begin
            if (cap_we_o) begin
               state_d = CAP_GNT;
            end
         end
         default:   state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q <= IDLE;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         if (cap_we_o) begin
            cnt_q <= cnt_q + 4'd1;
         end else if (state_q == START) begin
            cnt_q <= '0;
         end
      end
   end

endmodule

// File: mprog_param_regs.sv
module mprog_param_regs (
   input  logic                    clk_i,
   input  logic                    rst_ni,
   input  logic                    cap_we_i,
   input  logic [2:0]              cap_idx_i,
   input  mprog_pkg::mem_req_t     cap_word_i,
   output mprog_pkg::prog_params_t params_o
);

   mprog_pkg::prog_params_t     params_q;
   logic [mprog_pkg::DATA_W-1:0] wd;

   assign wd       = cap_word_i.wdata;
   assign params_o = params_q;

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         params_q <= '0;
      end else if (cap_we_i) begin
         unique case (cap_idx_i)
            // trigger word whose address is where commands go
            3'd0: begin
               params_q.cmd_flags <= wd[mprog_pkg::SIZE_W +: mprog_pkg::FLAG_W];
               params_q.max_size  <= wd[mprog_pkg::SIZE_W-1:0];
               params_q.cmd_addr  <= cap_word_i.addr;
            end
            3'd1: begin
               params_q.tcdm_base <= wd;
            end
            3'd2: begin
               params_q.ext_base <= wd;
            end
            3'd3: begin
               params_q.ext_stride <= wd;
            end
            3'd4: begin
               params_q.tcdm_stride <= wd;
            end
            // slot size in the low half and transfers per batch in the high half
            3'd5: begin
               params_q.slot_size <= wd[mprog_pkg::HALF_W-1:0];
               params_q.num_tr    <= wd[mprog_pkg::HALF_W +: mprog_pkg::CNT_W];
            end
            // size used by every transfer of the final batch
            3'd6: begin
               params_q.last_size <= wd[mprog_pkg::SIZE_W-1:0];
               params_q.num_batch <= wd[mprog_pkg::SIZE_W +: mprog_pkg::CNT_W];
            end
            3'd7: begin
               params_q.batch_ofs <= wd;
            end
         endcase
      end
   end

endmodule

// File: mprog_pkg.sv
package mprog_pkg;

   // bus widths, one word each for data and address
   localparam int unsigned DATA_W = 32;
   localparam int unsigned ADDR_W = 32;
   localparam int unsigned BE_W   = DATA_W / 8;
   localparam int unsigned HALF_W = DATA_W / 2;

   // command word layout, size in the low bits and flags above it
   localparam int unsigned SIZE_W = 19;
   localparam int unsigned FLAG_W = DATA_W - SIZE_W;

   // opcode field inside the command flags
   localparam int unsigned OPC_LSB = 19;
   localparam int unsigned OPC_W   = 4;

   // opcodes that start a program instead of a normal write
   localparam logic [OPC_W-1:0] OPC_PROG_A = 4'd6;
   localparam logic [OPC_W-1:0] OPC_PROG_B = 4'd7;

   // trigger word plus seven parameter words
   localparam int unsigned NUM_PARAM_WORDS = 8;

   // batch and transfer counters
   localparam int unsigned CNT_W = 13;

   // one request word, wen low means write
   typedef struct packed {
      logic              req;
      logic              wen;
      logic [BE_W-1:0]   be;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } mem_req_t;

   typedef struct packed {
      logic              gnt;
      logic              r_valid;
      logic [DATA_W-1:0] r_rdata;
   } mem_rsp_t;

   // decoded program parameters
   typedef struct packed {
      logic [FLAG_W-1:0] cmd_flags;
      logic [SIZE_W-1:0] max_size;
      logic [SIZE_W-1:0] last_size;
      logic [ADDR_W-1:0] tcdm_base;
      logic [ADDR_W-1:0] ext_base;
      logic [DATA_W-1:0] ext_stride;
      logic [DATA_W-1:0] tcdm_stride;
      logic [HALF_W-1:0] slot_size;
      logic [CNT_W-1:0]  num_tr;
      logic [CNT_W-1:0]  num_batch;
      logic [ADDR_W-1:0] batch_ofs;
      logic [ADDR_W-1:0] cmd_addr;
   } prog_params_t;

endpackage

// File: mprog_port_arb.sv
module mprog_port_arb (
   input  logic                clk_i,
   input  logic                rst_ni,
   input  mprog_pkg::mem_req_t pt_req_i,
   output mprog_pkg::mem_rsp_t pt_rsp_o,
   input  mprog_pkg::mem_req_t seq_req_i,
   output logic                seq_gnt_o,
   output mprog_pkg::mem_req_t dma_req_o,
   input  mprog_pkg::mem_rsp_t dma_rsp_i
);

   logic       pt_lock_q;
   logic [7:0] seq_pend_q;
   logic       seq_win;
   logic       pt_win;
   logic       seq_rsp;

   // sequencer first, pass-through only once its responses are back
   assign seq_win = seq_req_i.req && !pt_lock_q;
   assign pt_win  = pt_req_i.req && !seq_req_i.req && !pt_lock_q && (seq_pend_q == '0);
   assign seq_rsp = dma_rsp_i.r_valid && !pt_lock_q && (seq_pend_q != '0);

   always_comb begin
      dma_req_o     = seq_req_i.req ? seq_req_i : pt_req_i;
      dma_req_o.req = seq_win || pt_win;
   end

   assign seq_gnt_o        = seq_win && dma_rsp_i.gnt;
   assign pt_rsp_o.gnt     = pt_win && dma_rsp_i.gnt;
   assign pt_rsp_o.r_valid = pt_lock_q && dma_rsp_i.r_valid;
   assign pt_rsp_o.r_rdata = dma_rsp_i.r_rdata;

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         pt_lock_q  <= 1'b0;
         seq_pend_q <= '0;
      end else begin
         if (pt_rsp_o.gnt) begin
            pt_lock_q <= 1'b1;
         end else if (pt_rsp_o.r_valid) begin
            pt_lock_q <= 1'b0;
         end
         // responses still owed for sequencer words
         if (seq_gnt_o && !seq_rsp) begin
            seq_pend_q <= seq_pend_q + 8'd1;
         end else if (seq_rsp && !seq_gnt_o) begin
            seq_pend_q <= seq_pend_q - 8'd1;
         end
      end
   end

endmodule

// File: mprog_top.sv
module mprog_top (
   input  logic                clk_i,
   input  logic                rst_ni,
   input  mprog_pkg::mem_req_t core_req_i,
   output mprog_pkg::mem_rsp_t core_rsp_o,
   output mprog_pkg::mem_req_t dma_req_o,
   input  mprog_pkg::mem_rsp_t dma_rsp_i
);

   mprog_pkg::mem_req_t     pt_req;
   mprog_pkg::mem_rsp_t     pt_rsp;
   mprog_pkg::mem_req_t     cap_word;
   mprog_pkg::mem_req_t     seq_req;
   mprog_pkg::prog_params_t params;
   logic                    cap_we;
   logic [2:0]              cap_idx;
   logic                    prog_start;
   logic                    seq_busy;
   logic                    seq_gnt;

   mprog_front front_i (
      .clk_i, .rst_ni, .core_req_i, .core_rsp_o,
      .pt_req_o(pt_req), .pt_rsp_i(pt_rsp), .seq_busy_i(seq_busy),
      .cap_we_o(cap_we), .cap_idx_o(cap_idx), .cap_word_o(cap_word),
      .prog_start_o(prog_start)
   );

   mprog_param_regs param_regs_i (
      .clk_i, .rst_ni, .cap_we_i(cap_we), .cap_idx_i(cap_idx),
      .cap_word_i(cap_word), .params_o(params)
   );

   mprog_cmd_seq cmd_seq_i (
      .clk_i, .rst_ni, .prog_start_i(prog_start), .params_i(params),
      .seq_req_o(seq_req), .seq_gnt_i(seq_gnt), .seq_busy_o(seq_busy)
   );

   mprog_port_arb port_arb_i (
      .clk_i, .rst_ni, .pt_req_i(pt_req), .pt_rsp_o(pt_rsp),
      .seq_req_i(seq_req), .seq_gnt_o(seq_gnt), .dma_req_o, .dma_rsp_i
   );

endmodule

// File: tb_clk_gen.sv
module tb_clk_gen (
   output logic clk_o,
   output logic rst_no
);

   timeunit 1ns;
   timeprecision 100ps;

   // reset held low for the first 16 cycles
   initial begin
      clk_o  = 1'b0;
      rst_no = 1'b0;
      repeat (16) @(posedge clk_o);
      #1 rst_no = 1'b1;
   end

   always #5 clk_o = ~clk_o;

endmodule

// File: tb_mprog.sv
module tb_mprog;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int LIMIT = 2000;

   logic                clk;
   logic                rst_n;
   mprog_pkg::mem_req_t core_req;
   mprog_pkg::mem_rsp_t core_rsp;
   mprog_pkg::mem_req_t dma_req;
   mprog_pkg::mem_rsp_t dma_rsp;

   mprog_pkg::mem_req_t log_q[$];
   logic [31:0]         exp_q[$];
   logic [31:0]         got_q[$];
   logic [31:0]         ref_q[$];
   logic [31:0]         pw[8];
   logic [31:0]         trig_addr;
   logic [31:0]         lfsr;
   logic                rand_gnt = 1'b0;
   int                  last_first;
   int                  checks = 0;
   int                  errors = 0;
   int                  timeouts = 0;
   string               tname = "reset";

   tb_clk_gen clk_gen_i (.clk_o(clk), .rst_no(rst_n));

   mprog_top dut_i (
      .clk_i(clk), .rst_ni(rst_n), .core_req_i(core_req), .core_rsp_o(core_rsp),
      .dma_req_o(dma_req), .dma_rsp_i(dma_rsp)
   );

   // galois lfsr with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
   endfunction

   // dma port model with random grant and r_valid one cycle after each grant
   initial begin
      logic        hit;
      logic [31:0] addr;
      dma_rsp = '0;
      lfsr    = 32'hce55;
      forever begin
         @(negedge clk);
         hit  = dma_req.req && dma_rsp.gnt;
         addr = dma_req.addr;
         if (hit) begin
            log_q.push_back(dma_req);
         end
         @(posedge clk);
         #1;
         dma_rsp.r_valid = hit;
         dma_rsp.r_rdata = hit ? ~addr : '0;
         if (rand_gnt) begin
            dma_rsp.gnt = lfsr[0];
            lfsr        = lfsr_step(lfsr);
         end else begin
            dma_rsp.gnt = 1'b1;
         end
      end
   end

   // a waiting request must not move until granted
   assert property (@(posedge clk) disable iff (!rst_n)
      dma_req.req && !dma_rsp.gnt |=> dma_req.req && $stable(dma_req))
   else begin
      errors++;
      $display("dma request changed before its grant at %0t", $time);
   end

   task automatic finish_run();
      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   endtask

   task automatic timeout_abort(input string what);
      timeouts++;
      $display("timeout while waiting for %s in %s", what, tname);
      finish_run();
   endtask

   task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (exp === act) else begin
         errors++;
         $display("error %s, %s: expected %h, actual %h", tname, what, exp, act);
      end
   endtask

   // one core access with latencies counted in cycles
   task automatic core_access(input logic wen, input logic [3:0] be, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output int gnt_lat, output int rv_lat);
      @(posedge clk);
      #1;
      core_req = '{req: 1'b1, wen: wen, be: be, addr: addr, wdata: wdata};
      gnt_lat  = 0;
      @(negedge clk);
      while (!core_rsp.gnt) begin
         if (gnt_lat == LIMIT) begin
            timeout_abort("core grant");
         end
         @(negedge clk);
         gnt_lat++;
      end
      @(posedge clk);
      #1;
      core_req = '0;
      rv_lat   = 1;
      @(negedge clk);
      while (!core_rsp.r_valid) begin
         if (rv_lat == LIMIT) begin
            timeout_abort("core r_valid");
         end
         @(negedge clk);
         rv_lat++;
      end
      rdata = core_rsp.r_rdata;
   endtask

   task automatic pass_access(input logic wen, input logic [3:0] be, input logic [31:0] addr,
                              input logic [31:0] wdata);
      logic [31:0] rd;
      int          gl;
      int          rl;
      int          base;
      base = log_q.size();
      core_access(wen, be, addr, wdata, rd, gl, rl);
      check_val("logged words", base + 1, log_q.size());
      check_val("dma addr", addr, log_q[base].addr);
      check_val("dma wdata", wdata, log_q[base].wdata);
      check_val("dma wen and be", {wen, be}, {log_q[base].wen, log_q[base].be});
      check_val("r_valid delay", 1, rl);
      if (wen) begin
         check_val("read data", ~addr, rd);
      end
   endtask

   // predicted stream of five words per transfer
   task automatic build_expected();
      logic [15:0] nb;
      logic [15:0] ntr;
      logic [31:0] size;
      nb  = pw[6][31:19];
      ntr = pw[5][31:16];
      last_first = (nb - 1) * ntr * 5;
      exp_q.delete();
      for (int b = 0; b < nb; b++) begin
         for (int t = 0; t < ntr; t++) begin
            size = (b == nb - 1) ? pw[6][18:0] : pw[0][18:0];
            exp_q.push_back((pw[0] & 32'hfff8_0000) | size);
            exp_q.push_back(pw[1] + (b * ntr + t) * pw[5][15:0]);
            exp_q.push_back(pw[2] + b * pw[7] + t * pw[3]);
            exp_q.push_back(pw[3]);
            exp_q.push_back(pw[4]);
         end
      end
   endtask

   task automatic run_prog(input logic rd_during);
      logic [31:0] rd;
      int          gl;
      int          rl;
      int          n;
      int          base;
      int          stream_n;
      build_expected();
      base = log_q.size();
      for (int i = 0; i < 8; i++) begin
         core_access(1'b0, 4'hf, trig_addr + 4 * i, pw[i], rd, gl, rl);
         check_val($sformatf("param %0d gnt delay", i), 1, gl);
         check_val($sformatf("param %0d r_valid delay", i), 1, rl);
      end
      check_val("param words on dma port", base, log_q.size());
      // core read issued while the stream runs
      if (rd_during) begin
         core_access(1'b1, 4'hf, 32'h3000_0010, '0, rd, gl, rl);
         check_val("read data", ~32'h3000_0010, rd);
         check_val("read position", base + exp_q.size() + 1, log_q.size());
         check_val("read addr", 32'h3000_0010, log_q[base + exp_q.size()].addr);
      end
      n = 0;
      while (log_q.size() < base + exp_q.size()) begin
         if (n == LIMIT) begin
            timeout_abort("command stream");
         end
         @(negedge clk);
         n++;
      end
      // the stream is over once the sequencer drops busy
      n = 0;
      while (dut_i.seq_busy) begin
         if (n == LIMIT) begin
            timeout_abort("end of command stream");
         end
         @(negedge clk);
         n++;
      end
      stream_n = log_q.size() - base;
      if (rd_during) begin
         stream_n--;
      end
      got_q.delete();
      for (int i = 0; i < stream_n; i++) begin
         got_q.push_back(log_q[base + i].wdata);
      end
      check_val("stream length", exp_q.size(), got_q.size());
      for (int i = 0; i < exp_q.size(); i++) begin
         check_val($sformatf("word %0d addr", i), trig_addr, log_q[base + i].addr);
         check_val($sformatf("word %0d wen and be", i), 5'h0f,
                   {log_q[base + i].wen, log_q[base + i].be});
         check_val($sformatf("word %0d data", i), exp_q[i], log_q[base + i].wdata);
      end
      for (int i = last_first; i < got_q.size(); i += 5) begin
         check_val($sformatf("word %0d last size", i), pw[6][18:0], got_q[i][18:0]);
      end
   endtask

   initial begin
      int n;
      core_req = '0;
      n = 0;
      while (!rst_n) begin
         if (n == LIMIT) begin
            timeout_abort("reset release");
         end
         @(negedge clk);
         n++;
      end
      check_val("dma req", 0, dma_req.req);
      check_val("core gnt", 0, core_rsp.gnt);
      check_val("core r_valid", 0, core_rsp.r_valid);
      check_val("seq busy", 0, dut_i.seq_busy);
      check_val("prog start", 0, dut_i.prog_start);

      tname    = "pass-through";
      rand_gnt = 1'b1;
      pass_access(1'b0, 4'hf, 32'h0000_1230, 32'h0028_1111);
      pass_access(1'b1, 4'hf, 32'h0000_1234, 32'h0000_0000);
      pass_access(1'b0, 4'h3, 32'h0000_2000, 32'h0030_00ab);
      pass_access(1'b1, 4'h1, 32'h0000_2004, 32'h0038_0000);

      // three batches of two transfers with opcode 6
      pw = '{32'h8030_0400, 32'h0001_0000, 32'h8000_0000, 32'h0000_0100,
             32'h0000_0040, 32'h0002_0200, 32'h0018_0123, 32'h0001_0000};
      trig_addr = 32'h1000_0040;
      tname     = "command stream";
      rand_gnt  = 1'b0;
      run_prog(1'b0);
      ref_q = got_q;

      tname    = "back-pressure";
      rand_gnt = 1'b1;
      run_prog(1'b0);
      check_val("stream length", ref_q.size(), got_q.size());
      foreach (ref_q[i]) begin
         check_val($sformatf("word %0d against full-rate run", i), ref_q[i], got_q[i]);
      end

      tname     = "ordering";
      run_prog(1'b1);

      // single batch with opcode 7
      pw = '{32'h0038_0800, 32'h0002_0000, 32'h9000_0000, 32'h0000_0080,
             32'h0000_0020, 32'h0003_0100, 32'h0008_0077, 32'h0000_4000};
      trig_addr = 32'h1000_0080;
      tname     = "last batch size";
      run_prog(1'b0);

      finish_run();
   end

endmodule
